// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    ////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////

    localparam int CACHE_SETS  = 16;
    localparam int CACHE_WAYS  = 2;
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = $clog2(CACHE_SETS);
    localparam int TAG_BITS    = 9;

    // Index from address bits 6:3, tag from bits 15:7
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   ctag_t;
    typedef logic                  way_t;

    // Miss sequencing
    typedef enum logic [1:0] {
        MS_IDLE      = 2'h0,
        MS_WRITEBACK = 2'h1,
        MS_LOAD_REQ  = 2'h2,
        MS_WAIT_FILL = 2'h3
    } miss_state_e;

endpackage

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // Byte address, low three bits ignored (whole doublewords only)
    localparam int ADDR_BITS = 16;
    typedef logic [ADDR_BITS-1:0] addr_t;

    typedef logic [63:0] dword_t;

    // Transaction tag, zero means no transaction
    localparam int MEM_TAG_BITS = 4;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // Highest tag value, also the limit on loads in flight
    localparam mem_tag_t MEM_TAG_MAX = 4'd15;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_cmd_e;

    // Cycles from load acceptance to data return
    localparam int MEM_LATENCY = 4;

    localparam int MEM_WORDS     = 8192;
    localparam int MEM_WORD_BITS = $clog2(MEM_WORDS);

endpackage

// ==== dcache/dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  index_t index,
    input  ctag_t  ctag,
    input  dword_t wr_data,

    input  logic   fill_en,
    input  logic   store_en,
    input  logic   touch_en,
    input  logic   clean_en,
    input  dword_t fill_data,

    output logic   hit,
    output way_t   hit_way,
    output dword_t hit_data,

    output way_t   victim_way,
    output logic   victim_valid,
    output logic   victim_dirty,
    output ctag_t  victim_tag,
    output dword_t victim_data
);

    ////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////

    dword_t                data_q  [CACHE_WAYS][CACHE_SETS];
    ctag_t                 tag_q   [CACHE_WAYS][CACHE_SETS];
    logic [CACHE_SETS-1:0] valid_q [CACHE_WAYS];
    logic [CACHE_SETS-1:0] dirty_q [CACHE_WAYS];

    // One bit per set, names the least recently used way
    logic [CACHE_SETS-1:0] lru_q;

    logic [CACHE_WAYS-1:0] way_match;
    way_t                  write_way;
    way_t                  used_way;

    ////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < CACHE_WAYS; w++) begin
            way_match[w] = valid_q[w][index] && (tag_q[w][index] == ctag);
        end
    end

    assign hit      = |way_match;
    assign hit_way  = way_t'(way_match[1]);
    assign hit_data = data_q[hit_way][index];

    // Prefer an empty way, else evict the LRU one
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    assign victim_valid = valid_q[victim_way][index];
    assign victim_dirty = dirty_q[victim_way][index];
    assign victim_tag   = tag_q[victim_way][index];
    assign victim_data  = data_q[victim_way][index];

    // Store hits overwrite in place, everything else lands in the victim
    assign write_way = (store_en && hit) ? hit_way : victim_way;
    assign used_way  = touch_en ? hit_way : write_way;

    ////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < CACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (fill_en || store_en) begin
                valid_q[write_way][index] <= 1'b1;
                dirty_q[write_way][index] <= store_en;
            end else if (clean_en) begin
                valid_q[victim_way][index] <= 1'b0;
                dirty_q[victim_way][index] <= 1'b0;
            end
            if (fill_en || store_en || touch_en) begin
                lru_q[index] <= ~used_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en || store_en) begin
            tag_q[write_way][index]  <= ctag;
            data_q[write_way][index] <= store_en ? wr_data : fill_data;
        end
    end

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // Processor side
    input  logic     read_en,
    input  logic     write_en,
    input  addr_t    addr,
    output logic     data_valid,
    output logic     write_done,

    // Array status
    input  logic     hit,
    input  logic     victim_valid,
    input  logic     victim_dirty,
    input  ctag_t    victim_tag,
    input  dword_t   victim_data,

    // Array updates
    output logic     fill_en,
    output logic     store_en,
    output logic     touch_en,
    output logic     clean_en,
    output dword_t   fill_data,

    // Memory side
    output bus_cmd_e mem_cmd,
    output addr_t    mem_addr,
    output dword_t   mem_wdata,
    input  mem_tag_t mem_response,
    input  mem_tag_t mem_rtag,
    input  dword_t   mem_rdata
);

    miss_state_e state_q;
    miss_state_e state_d;
    mem_tag_t    load_tag_q;

    index_t      index;
    addr_t       line_addr;
    addr_t       victim_addr;
    logic        needs_wb;
    logic        accepted;

    assign index       = addr[OFFSET_BITS +: INDEX_BITS];
    assign line_addr   = {addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    // Victim address rebuilt from its stored tag and the current set
    assign victim_addr = {victim_tag, index, {OFFSET_BITS{1'b0}}};
    assign needs_wb    = victim_valid && victim_dirty;
    assign accepted    = (mem_response != '0);

    ////////////////////////////////////////////////
    // Processor answers
    ////////////////////////////////////////////////

    assign data_valid = (state_q == MS_IDLE) && read_en && hit;
    assign write_done = (state_q == MS_IDLE) && write_en && !read_en && (hit || !needs_wb);
    assign touch_en   = data_valid;
    assign store_en   = write_done;
    assign fill_data  = mem_rdata;

    ////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////

    always_comb begin
        state_d   = state_q;
        mem_cmd   = BUS_NONE;
        mem_addr  = line_addr;
        mem_wdata = '0;
        clean_en  = 1'b0;
        fill_en   = 1'b0;

        case (state_q)
            MS_IDLE: begin
                if (read_en && !hit) begin
                    state_d = needs_wb ? MS_WRITEBACK : MS_LOAD_REQ;
                end else if (write_en && !read_en && !hit && needs_wb) begin
                    state_d = MS_WRITEBACK;
                end
            end
            MS_WRITEBACK: begin
                mem_cmd   = BUS_STORE;
                mem_addr  = victim_addr;
                mem_wdata = victim_data;
                if (accepted) begin
                    clean_en = 1'b1;
                    // A pending store finishes from idle once the way is free
                    state_d  = read_en ? MS_LOAD_REQ : MS_IDLE;
                end
            end
            MS_LOAD_REQ: begin
                mem_cmd = BUS_LOAD;
                if (accepted) begin
                    state_d = MS_WAIT_FILL;
                end
            end
            MS_WAIT_FILL: begin
                // Only our own tag counts as the fill
                if (mem_rtag == load_tag_q) begin
                    fill_en = 1'b1;
                    state_d = MS_IDLE;
                end
            end
            default: begin
                state_d = MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= MS_IDLE;
            load_tag_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == MS_LOAD_REQ && accepted) begin
                load_tag_q <= mem_response;
            end
        end
    end

endmodule

// ==== dcache_sys.f ====
common/mem_bus_pkg.sv
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
hdl/tagged_mem.sv
hdl/dcache_sys.sv
test/dcache_sys_checker.sv
test/dcache_sys_tb.sv

// ==== hdl/dcache_sys.sv ====
`timescale 1ns/1ps

module dcache_sys
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  logic   read_en,
    input  logic   write_en,
    input  addr_t  addr,
    input  dword_t wr_data,

    output dword_t rd_data,
    output logic   data_valid,
    output logic   write_done
);

    index_t   index;
    ctag_t    ctag;

    // Array status
    logic     hit;
    dword_t   hit_data;
    logic     victim_valid;
    logic     victim_dirty;
    ctag_t    victim_tag;
    dword_t   victim_data;

    // Array updates
    logic     fill_en;
    logic     store_en;
    logic     touch_en;
    logic     clean_en;
    dword_t   fill_data;

    // Memory bus
    bus_cmd_e mem_cmd;
    addr_t    mem_addr;
    dword_t   mem_wdata;
    mem_tag_t mem_response;
    mem_tag_t mem_rtag;
    dword_t   mem_rdata;

    assign index   = addr[OFFSET_BITS +: INDEX_BITS];
    assign ctag    = addr[ADDR_BITS-1 -: TAG_BITS];
    assign rd_data = hit_data;

    dcache_ctrl i_dcache_ctrl (
        .clock, .reset,
        .read_en, .write_en, .addr, .data_valid, .write_done,
        .hit, .victim_valid, .victim_dirty, .victim_tag, .victim_data,
        .fill_en, .store_en, .touch_en, .clean_en, .fill_data,
        .mem_cmd, .mem_addr, .mem_wdata, .mem_response, .mem_rtag, .mem_rdata
    );

    dcache_array i_dcache_array (
        .clock, .reset,
        .index, .ctag, .wr_data,
        .fill_en, .store_en, .touch_en, .clean_en, .fill_data,
        .hit, .hit_way(), .hit_data,
        .victim_way(), .victim_valid, .victim_dirty, .victim_tag, .victim_data
    );

    tagged_mem i_tagged_mem (
        .clock, .reset,
        .mem_cmd, .mem_addr, .mem_wdata,
        .mem_response, .mem_rtag, .mem_rdata
    );

endmodule

// ==== hdl/tagged_mem.sv ====
`timescale 1ns/1ps

module tagged_mem
    import mem_bus_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    input  bus_cmd_e mem_cmd,
    input  addr_t    mem_addr,
    input  dword_t   mem_wdata,

    output mem_tag_t mem_response,
    output mem_tag_t mem_rtag,
    output dword_t   mem_rdata
);

    dword_t mem_q [MEM_WORDS] = '{default: '0};

    mem_tag_t next_tag_q;
    logic [MEM_TAG_BITS-1:0] in_flight_q;

    // Return pipeline, stage 0 loaded at acceptance
    mem_tag_t tag_pipe_q  [MEM_LATENCY];
    dword_t   data_pipe_q [MEM_LATENCY];

    logic accept;
    logic load_accept;
    logic load_return;
    logic [MEM_WORD_BITS-1:0] word;

    assign word        = mem_addr[ADDR_BITS-1 -: MEM_WORD_BITS];
    // Busy only when every tag is held by a load
    assign accept      = (mem_cmd != BUS_NONE) && (in_flight_q != MEM_TAG_MAX);
    assign load_accept = accept && (mem_cmd == BUS_LOAD);
    assign load_return = (mem_rtag != '0);

    assign mem_response = accept ? next_tag_q : '0;
    assign mem_rtag     = tag_pipe_q[MEM_LATENCY-1];
    assign mem_rdata    = data_pipe_q[MEM_LATENCY-1];

    ////////////////////////////////////////////////
    // Tag bookkeeping
    ////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag_q  <= mem_tag_t'(1);
            in_flight_q <= '0;
            for (int s = 0; s < MEM_LATENCY; s++) begin
                tag_pipe_q[s] <= '0;
            end
        end else begin
            if (accept) begin
                // Wrap from 15 back to 1, zero is never handed out
                next_tag_q <= (next_tag_q == MEM_TAG_MAX) ? mem_tag_t'(1) : next_tag_q + 1'b1;
            end
            if (load_accept && !load_return) begin
                in_flight_q <= in_flight_q + 1'b1;
            end else if (!load_accept && load_return) begin
                in_flight_q <= in_flight_q - 1'b1;
            end
            tag_pipe_q[0] <= load_accept ? next_tag_q : '0;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                tag_pipe_q[s] <= tag_pipe_q[s-1];
            end
        end
    end

    ////////////////////////////////////////////////
    // Array and read data
    ////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (accept && mem_cmd == BUS_STORE) begin
            mem_q[word] <= mem_wdata;
        end
    end

    always_ff @(posedge clock) begin
        data_pipe_q[0] <= mem_q[word];
        for (int s = 1; s < MEM_LATENCY; s++) begin
            data_pipe_q[s] <= data_pipe_q[s-1];
        end
    end

endmodule

// ==== test/dcache_sys_checker.sv ====
`timescale 1ns/1ps

module dcache_sys_checker
    import mem_bus_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     read_en,
    input logic     write_en,
    input logic     data_valid,
    input logic     write_done,
    input bus_cmd_e mem_cmd,
    input mem_tag_t mem_response,
    input mem_tag_t mem_rtag
);

    // Failed assertion count
    int unsigned fail_count = 0;

    logic load_accepted;

    assign load_accepted = (mem_cmd == BUS_LOAD) && (mem_response != '0);

    ////////////////////////////////////////////////
    // Processor side
    ////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (reset) data_valid |-> read_en)
    else begin
        fail_count++;
        $error("data_valid high without read_en");
    end

    // Store answers only when no read competes
    assert property (@(posedge clock) disable iff (reset)
        write_done |-> (write_en && !read_en))
    else begin
        fail_count++;
        $error("write_done high without a lone write_en");
    end

    ////////////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////////////

    assert property (@(posedge clock) reset |-> (mem_cmd == BUS_NONE))
    else begin
        fail_count++;
        $error("memory command issued during reset");
    end

    // Accepted load comes back with its own tag
    assert property (@(posedge clock) disable iff (reset)
        load_accepted |-> ##MEM_LATENCY (mem_rtag == $past(mem_response, MEM_LATENCY)))
    else begin
        fail_count++;
        $error("load tag not returned after the memory latency");
    end

    assert property (@(posedge clock) disable iff (reset)
        (mem_rtag != '0) |-> $past(load_accepted, MEM_LATENCY))
    else begin
        fail_count++;
        $error("returned tag without a matching accepted load");
    end

endmodule

bind dcache_sys dcache_sys_checker i_checker (
    .clock, .reset, .read_en, .write_en, .data_valid, .write_done,
    .mem_cmd, .mem_response, .mem_rtag
);

// ==== test/dcache_sys_tb.sv ====
`timescale 1ns/1ps

module dcache_sys_tb
    import mem_bus_pkg::*;
    import dcache_pkg::*;
();

    localparam int SEED           = 89;
    localparam int RANDOM_OPS     = 400;
    localparam int DIRECTED_OPS   = 17;
    localparam int TOTAL_OPS      = DIRECTED_OPS + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * (2 * MEM_LATENCY + 8) + 100;

    logic   clock;
    logic   reset;
    logic   read_en;
    logic   write_en;
    addr_t  addr;
    dword_t wr_data;
    dword_t rd_data;
    logic   data_valid;
    logic   write_done;

    // Reference memory keyed by line address with zero as the default
    dword_t      ref_mem [addr_t];
    int unsigned load_hits;
    int unsigned load_misses;

    dcache_sys i_dcache_sys (
        .clock, .reset,
        .read_en, .write_en, .addr, .wr_data,
        .rd_data, .data_valid, .write_done
    );

    ////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        abort_run($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic addr_t line_of(input addr_t a);
        return {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic addr_t make_addr(input ctag_t tag, input index_t index);
        return {tag, index, {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic dword_t model_read(input addr_t a);
        if (ref_mem.exists(line_of(a))) begin
            return ref_mem[line_of(a)];
        end
        return '0;
    endfunction

    // Called and returns 1 ns after a rising edge
    task automatic store_word(input addr_t a, input dword_t d);
        write_en = 1'b1;
        addr     = a;
        wr_data  = d;
        @(negedge clock);
        while (write_done !== 1'b1) begin
            @(negedge clock);
        end
        ref_mem[line_of(a)] = d;
        @(posedge clock);
        #1;
        write_en = 1'b0;
    endtask

    task automatic load_word(input addr_t a, output int waits);
        dword_t expected;
        waits   = 0;
        read_en = 1'b1;
        addr    = a;
        @(negedge clock);
        while (data_valid !== 1'b1) begin
            waits++;
            @(negedge clock);
        end
        expected = model_read(a);
        assert (rd_data === expected)
        else flag_mismatch("rd_data", expected, rd_data);
        if (waits == 0) begin
            load_hits++;
        end else begin
            load_misses++;
        end
        @(posedge clock);
        #1;
        read_en = 1'b0;
    endtask

    ////////////////////////////////////////////////
    // Clock, watchdog, checker monitor
    ////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        abort_run($sformatf("Run timed out after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        wait (i_dcache_sys.i_checker.fail_count != 0);
        abort_run("A protocol assertion in the checker failed");
    end

    ////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////

    initial begin
        int     waits;
        ctag_t  tag;
        index_t index;
        dword_t data;
        addr_t  a;

        void'($urandom(SEED));
        reset       = 1'b1;
        read_en     = 1'b0;
        write_en    = 1'b0;
        addr        = '0;
        wr_data     = '0;
        load_hits   = 0;
        load_misses = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        // Idle outputs after reset and a cold miss that reads zero
        @(negedge clock);
        assert (data_valid === 1'b0) else flag_mismatch("data_valid", 0, data_valid);
        assert (write_done === 1'b0) else flag_mismatch("write_done", 0, write_done);
        assert (i_dcache_sys.mem_cmd === BUS_NONE)
        else flag_mismatch("mem_cmd", BUS_NONE, i_dcache_sys.mem_cmd);
        @(posedge clock);
        #1;
        load_word(make_addr(9'h1ab, 4'h2), waits);
        assert (waits == MEM_LATENCY + 2)
        else abort_run($sformatf("Cold load took %0d wait cycles", waits));

        // Store then load hits in the same cycle
        store_word(make_addr(9'h022, 4'h7), 64'h0123_4567_89ab_cdef);
        load_word(make_addr(9'h022, 4'h7), waits);
        assert (waits == 0) else abort_run("Load after a store to the same line missed");

        // Read wins when both strobes are high and the store is dropped
        write_en = 1'b1;
        wr_data  = 64'hdead_beef_dead_beef;
        load_word(make_addr(9'h022, 4'h7), waits);
        write_en = 1'b0;
        load_word(make_addr(9'h022, 4'h7), waits);

        // Three tags in one set force dirty write-backs
        for (int i = 0; i < 3; i++) begin
            store_word(make_addr(ctag_t'(9'h100 + i), 4'h5), 64'hface_0000_0000_0000 + i);
        end
        for (int i = 0; i < 3; i++) begin
            load_word(make_addr(ctag_t'(9'h100 + i), 4'h5), waits);
        end

        // A, B, A, C leaves A resident and B evicted
        store_word(make_addr(9'h010, 4'h9), 64'haaaa_0000_0000_0001);
        store_word(make_addr(9'h011, 4'h9), 64'hbbbb_0000_0000_0002);
        load_word(make_addr(9'h010, 4'h9), waits);
        assert (waits == 0) else abort_run("Line A missed before replacement");
        store_word(make_addr(9'h012, 4'h9), 64'hcccc_0000_0000_0003);
        load_word(make_addr(9'h010, 4'h9), waits);
        assert (waits == 0) else abort_run("Recently used line A was evicted");
        load_word(make_addr(9'h011, 4'h9), waits);
        assert (waits > 0) else abort_run("LRU line B still hit after replacement");

        // 64 addresses over four sets with sixteen tags each
        for (int n = 0; n < RANDOM_OPS; n++) begin
            index = index_t'(4 * $urandom_range(0, 3));
            tag   = ctag_t'(9'h040 + $urandom_range(0, 15));
            a     = make_addr(tag, index) | addr_t'($urandom_range(0, 7));
            if ($urandom_range(0, 1) == 0) begin
                data = {$urandom, $urandom};
                store_word(a, data);
            end else begin
                load_word(a, waits);
            end
        end

        assert (load_hits > 0 && load_misses > 0)
        else abort_run("Loads did not cover both hits and misses");
        $display("Loads: %0d hits, %0d misses", load_hits, load_misses);
        if (i_dcache_sys.i_checker.fail_count != 0) begin
            abort_run("A protocol assertion in the checker failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule
